// ==== dv/tb_tests.svh ====
// RV32I opcodes and encoders for the directed programs
localparam logic [6:0]  OPC_OP     = 7'b0110011;
localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
localparam logic [6:0]  OPC_LUI    = 7'b0110111;
localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
localparam logic [6:0]  OPC_STORE  = 7'b0100011;
localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
localparam logic [6:0]  OPC_JAL    = 7'b1101111;
localparam logic [31:0] NOP        = 32'h00000013;
localparam logic [31:0] MARKER     = 32'hbad0c0de;

function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3,
                                       input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] funct3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, funct3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

task automatic put_instr(input logic [31:0] word);
    imem[8'(next_slot)] = word;
    next_slot++;
endtask

// LUI plus ADDI, upper part rounded for the signed low half
task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    put_instr(u_type(hi[31:12], rd));
    put_instr(i_type(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
endtask

task automatic store_word(input logic [4:0] rs, input int slot);
    put_instr(s_type(12'(slot * 4), rs, 5'd0));
endtask

task automatic r_op_then_store(input logic [6:0] funct7, input logic [2:0] funct3,
                               input logic [4:0] rs1, input logic [4:0] rs2, input int slot);
    put_instr(r_type(funct7, rs2, rs1, funct3, 5'd3));
    store_word(5'd3, slot);
endtask

task automatic i_op_then_store(input logic [2:0] funct3, input logic [4:0] rs1,
                               input logic [11:0] imm, input int slot);
    put_instr(i_type(imm, rs1, funct3, 5'd3, OPC_OP_IMM));
    store_word(5'd3, slot);
endtask

// Core held in reset while the program is loaded
task automatic begin_test();
    @(negedge clk);
    arst_n      = 1'b0;
    preload_idx = '0;
    preload_val = fill_word(0);
    next_slot   = 0;
    for (int k = 0; k < IMEM_DEPTH; k++) begin
        imem[k] = 32'h0;
    end
endtask

task automatic run_program();
    put_instr(j_type(21'd0, 5'd0));
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    repeat (RUN_CYCLES) @(negedge clk);
endtask

task automatic reset_behavior();
    begin_test();
    for (int k = 0; k < 12; k++) begin
        put_instr(NOP);
    end
    for (int k = 0; k < RESET_CYCLES; k++) begin
        @(negedge clk);
        check_word("imem_addr_o", 32'd0, imem_addr);
        check_word("dmem_we_o", 32'd0, 32'(dmem_we));
    end
    arst_n = 1'b1;
    for (int k = 1; k <= 8; k++) begin
        @(negedge clk);
        check_word("imem_addr_o", 32'(4 * k), imem_addr);
        check_word("dmem_we_o", 32'd0, 32'(dmem_we));
    end
endtask

task automatic alu_results();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm [5];
    logic [31:0] exp_val [13];
    a = next_rand();
    b = next_rand();
    for (int k = 0; k < 5; k++) begin
        r = next_rand();
        imm[k] = r[11:0];
    end
    r = next_rand();
    begin_test();
    load_const(5'd1, a);
    load_const(5'd2, b);
    r_op_then_store(7'h00, 3'b000, 5'd1, 5'd2, 0);
    r_op_then_store(7'h20, 3'b000, 5'd1, 5'd2, 1);
    r_op_then_store(7'h00, 3'b111, 5'd1, 5'd2, 2);
    r_op_then_store(7'h00, 3'b110, 5'd1, 5'd2, 3);
    r_op_then_store(7'h00, 3'b100, 5'd1, 5'd2, 4);
    r_op_then_store(7'h00, 3'b010, 5'd1, 5'd2, 5);
    r_op_then_store(7'h00, 3'b010, 5'd2, 5'd1, 6);
    i_op_then_store(3'b000, 5'd1, imm[0], 7);
    i_op_then_store(3'b111, 5'd1, imm[1], 8);
    i_op_then_store(3'b110, 5'd1, imm[2], 9);
    i_op_then_store(3'b100, 5'd1, imm[3], 10);
    i_op_then_store(3'b010, 5'd1, imm[4], 11);
    put_instr(u_type(r[31:12], 5'd3));
    store_word(5'd3, 12);
    run_program();
    exp_val[0]  = a + b;
    exp_val[1]  = a - b;
    exp_val[2]  = a & b;
    exp_val[3]  = a | b;
    exp_val[4]  = a ^ b;
    exp_val[5]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exp_val[6]  = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    exp_val[7]  = a + sext12(imm[0]);
    exp_val[8]  = a & sext12(imm[1]);
    exp_val[9]  = a | sext12(imm[2]);
    exp_val[10] = a ^ sext12(imm[3]);
    exp_val[11] = ($signed(a) < $signed(sext12(imm[4]))) ? 32'd1 : 32'd0;
    exp_val[12] = {r[31:12], 12'h000};
    for (int k = 0; k < 13; k++) begin
        check_word($sformatf("dmem[%0d]", k), exp_val[k], dmem[k]);
    end
endtask

task automatic forwarding_paths();
    logic [31:0] a;
    logic [31:0] e2;
    logic [31:0] e3;
    logic [31:0] e4;
    logic [31:0] e5;
    a = next_rand();
    begin_test();
    load_const(5'd1, a);
    // Back to back
    put_instr(i_type(12'd5, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
    put_instr(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
    put_instr(NOP);
    // One apart on x3
    put_instr(i_type(12'ha5a, 5'd3, 3'b100, 5'd4, OPC_OP_IMM));
    put_instr(r_type(7'h20, 5'd2, 5'd4, 3'b000, 5'd5));
    put_instr(NOP);
    put_instr(NOP);
    // x5 read in the cycle it is written
    put_instr(r_type(7'h00, 5'd1, 5'd5, 3'b000, 5'd6));
    // A write to x0 is dropped
    put_instr(i_type(12'd123, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
    put_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd7));
    put_instr(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd8));
    for (int k = 2; k <= 8; k++) begin
        store_word(5'(k), 14 + k);
    end
    run_program();
    e2 = a + 32'd5;
    e3 = e2 + a;
    e4 = e3 ^ 32'hfffffa5a;
    e5 = e4 - e2;
    check_word("dmem[16]", e2, dmem[16]);
    check_word("dmem[17]", e3, dmem[17]);
    check_word("dmem[18]", e4, dmem[18]);
    check_word("dmem[19]", e5, dmem[19]);
    check_word("dmem[20]", e5 + a, dmem[20]);
    check_word("dmem[21]", 32'd0, dmem[21]);
    check_word("dmem[22]", a, dmem[22]);
endtask

task automatic load_use_stall();
    logic [31:0] v;
    logic [31:0] r;
    v = next_rand();
    r = next_rand();
    begin_test();
    preload_idx = DMEM_AW'(30);
    preload_val = v;
    put_instr(i_type(12'd120, 5'd0, 3'b010, 5'd8, OPC_LOAD));
    put_instr(i_type(r[11:0], 5'd8, 3'b000, 5'd9, OPC_OP_IMM));
    store_word(5'd9, 31);
    // Loaded word used as store data
    put_instr(i_type(12'd120, 5'd0, 3'b010, 5'd10, OPC_LOAD));
    store_word(5'd10, 32);
    put_instr(i_type(12'd120, 5'd0, 3'b010, 5'd11, OPC_LOAD));
    put_instr(r_type(7'h00, 5'd11, 5'd11, 3'b000, 5'd12));
    store_word(5'd12, 33);
    run_program();
    check_word("dmem[31]", v + sext12(r[11:0]), dmem[31]);
    check_word("dmem[32]", v, dmem[32]);
    check_word("dmem[33]", v + v, dmem[33]);
endtask

task automatic branch_and_jal();
    logic [31:0] link_exp;
    begin_test();
    load_const(5'd20, MARKER);
    put_instr(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    put_instr(i_type(12'd5, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    put_instr(i_type(12'd9, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
    // BEQ taken over two marker stores
    put_instr(b_type(13'd12, 5'd2, 5'd1, 3'b000));
    store_word(5'd20, 50);
    store_word(5'd20, 51);
    put_instr(i_type(12'd1, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
    store_word(5'd10, 40);
    // BEQ not taken, a wrong jump skips the ADDI
    put_instr(b_type(13'd12, 5'd3, 5'd1, 3'b000));
    put_instr(i_type(12'd2, 5'd0, 3'b000, 5'd11, OPC_OP_IMM));
    store_word(5'd11, 41);
    put_instr(b_type(13'd12, 5'd3, 5'd1, 3'b001));
    store_word(5'd20, 52);
    store_word(5'd20, 53);
    put_instr(b_type(13'd12, 5'd2, 5'd1, 3'b001));
    put_instr(i_type(12'd3, 5'd0, 3'b000, 5'd12, OPC_OP_IMM));
    store_word(5'd12, 42);
    link_exp = 32'(4 * next_slot + 4);
    put_instr(j_type(21'd12, 5'd13));
    store_word(5'd20, 54);
    store_word(5'd20, 55);
    store_word(5'd13, 43);
    run_program();
    check_word("dmem[40]", 32'd1, dmem[40]);
    check_word("dmem[41]", 32'd2, dmem[41]);
    check_word("dmem[42]", 32'd3, dmem[42]);
    check_word("dmem[43]", link_exp, dmem[43]);
    for (int w = 0; w < DMEM_DEPTH; w++) begin
        check_true(dmem[w] !== MARKER,
                   $sformatf("marker from a flushed store found in data memory word %0d", w));
    end
endtask

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int RUN_CYCLES      = 150;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + RUN_CYCLES + 2) + 100;
    localparam int DMEM_AW         = 6;
    localparam int DMEM_DEPTH      = 1 << DMEM_AW;
    localparam int IMEM_DEPTH      = 256;
    localparam logic [31:0] LCG_SEED = 32'h4fd17b9e;

    logic               clk;
    logic               arst_n;
    logic [31:0]        imem_addr;
    logic [31:0]        imem_data;
    logic [DMEM_AW-1:0] dmem_addr;
    logic               dmem_we;
    logic [31:0]        dmem_wdata;
    logic [31:0]        dmem_rdata;

    logic [31:0]        imem [IMEM_DEPTH];
    logic [31:0]        dmem [DMEM_DEPTH];
    int                 next_slot;
    logic [DMEM_AW-1:0] preload_idx;
    logic [31:0]        preload_val;
    logic [31:0]        lcg_state;
    int                 error_count;
    int                 check_count;

    rv_core #(
        .DMEM_AW (DMEM_AW)
    ) i_dut (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_we_o    (dmem_we),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Both memories read combinationally
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr];

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hf1110000 | 32'(idx);
    endfunction

    // Reset reloads the fill pattern plus one preloaded word
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int a = 0; a < DMEM_DEPTH; a++) begin
                dmem[a] <= fill_word(a);
            end
            dmem[preload_idx] <= preload_val;
        end else if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("mismatch at time %0t: %s expected 0x%08h actual 0x%08h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("error at time %0t: %s", $time, what);
        end
    endtask

`include "tb_tests.svh"

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks run %0d, errors %0d", check_count, error_count);
        $display("Regression failed");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        preload_idx = '0;
        preload_val = '0;
        next_slot   = 0;
        lcg_state   = LCG_SEED;
        error_count = 0;
        check_count = 0;
        reset_behavior();
        alu_results();
        forwarding_paths();
        load_use_stall();
        branch_and_jal();
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_rv_core -o sim_tb_rv_core

output="$(./obj_dir/sim_tb_rv_core)"
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic [4:0]        id_rs1_i,
    input  logic [4:0]        id_rs2_i,
    input  logic [4:0]        ex_rs1_i,
    input  logic [4:0]        ex_rs2_i,
    input  logic [4:0]        ex_rd_i,
    input  logic              ex_valid_i,
    input  logic              ex_mem_re_i,
    input  logic [4:0]        mem_rd_i,
    input  logic              mem_rf_we_i,
    input  logic [4:0]        wb_rd_i,
    input  logic              wb_rf_we_i,
    input  logic              redirect_i,
    output logic              stall_o,
    output logic              flush_o,
    output rv_pkg::fwd_sel_e  fwd_a_o,
    output rv_pkg::fwd_sel_e  fwd_b_o
);

    logic load_use;

    // Load in execute whose result decode needs right away
    assign load_use = ex_valid_i && ex_mem_re_i && (ex_rd_i != 5'd0) &&
                      ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

    assign stall_o = load_use;
    assign flush_o = redirect_i;

    // Memory stage is younger, so it wins over writeback
    function automatic rv_pkg::fwd_sel_e pick_source(input logic [4:0] src);
        if (src != 5'd0 && mem_rf_we_i && mem_rd_i == src) begin
            return rv_pkg::FWD_MEM;
        end
        if (src != 5'd0 && wb_rf_we_i && wb_rd_i == src) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    always_comb begin
        fwd_a_o = pick_source(ex_rs1_i);
        fwd_b_o = pick_source(ex_rs2_i);
    end

endmodule

`default_nettype wire

// ==== source/pipe_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_decode (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      stall_i,
    input  logic                      flush_i,
    stage_if.consumer                 if_id_i,
    stage_if.producer                 id_ex_o,
    output logic [4:0]                rs1_idx_o,
    output logic [4:0]                rs2_idx_o,
    input  logic [rv_pkg::XLEN-1:0]   rs1_val_i,
    input  logic [rv_pkg::XLEN-1:0]   rs2_val_i
);

    logic [rv_pkg::XLEN-1:0] instr;
    rv_pkg::opcode_e         opc;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;
    rv_pkg::id_ex_t          dec;
    logic                    dec_ok;

    assign instr     = if_id_i.payload.instr;
    assign opc       = rv_pkg::opcode_e'(instr[6:0]);
    assign rs1_idx_o = instr[19:15];
    assign rs2_idx_o = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec         = '0;
        dec.pc      = if_id_i.payload.pc;
        dec.rs1_val = rs1_val_i;
        dec.rs2_val = rs2_val_i;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.alu_op  = rv_pkg::ALU_ADD;
        dec.wb_sel  = rv_pkg::WB_ALU;
        dec_ok      = 1'b1;
        case (opc)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                dec.rf_we   = 1'b1;
                dec.use_imm = (opc == rv_pkg::OPC_OP_IMM);
                dec.imm     = imm_i;
                case (instr[14:12])
                    3'b000: begin
                        // funct7 bit 5 picks SUB for register forms only
                        if (opc == rv_pkg::OPC_OP && instr[30]) begin
                            dec.alu_op = rv_pkg::ALU_SUB;
                        end
                    end
                    3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rv_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rv_pkg::ALU_AND;
                    default: dec_ok = 1'b0;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                dec.rf_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OPC_LOAD: begin
                dec.rf_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.mem_re  = 1'b1;
                dec.wb_sel  = rv_pkg::WB_LOAD;
            end
            rv_pkg::OPC_STORE: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
                dec.mem_we  = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                // Only BEQ and BNE
                dec.is_branch = 1'b1;
                dec.branch_ne = instr[12];
                dec.imm       = imm_b;
                dec_ok        = (instr[14:13] == 2'b00);
            end
            rv_pkg::OPC_JAL: begin
                dec.is_jal = 1'b1;
                dec.rf_we  = 1'b1;
                dec.imm    = imm_j;
                dec.wb_sel = rv_pkg::WB_PC4;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o.valid <= if_id_i.valid && dec_ok && !stall_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_o.payload <= dec;
    end

endmodule

`default_nettype wire

// ==== source/pipe_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_execute (
    input  logic                      clk,
    input  logic                      arst_n_i,
    stage_if.consumer                 id_ex_i,
    stage_if.producer                 ex_mem_o,
    input  rv_pkg::fwd_sel_e          fwd_a_i,
    input  rv_pkg::fwd_sel_e          fwd_b_i,
    input  logic [rv_pkg::XLEN-1:0]   mem_fwd_i,
    input  logic [rv_pkg::XLEN-1:0]   wb_fwd_i,
    output logic                      redirect_o,
    output logic [rv_pkg::XLEN-1:0]   target_o
);

    rv_pkg::id_ex_t          ex;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b_reg;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic                    taken;

    assign ex = id_ex_i.payload;

    function automatic logic [rv_pkg::XLEN-1:0] fwd_mux(
        input rv_pkg::fwd_sel_e       sel,
        input logic [rv_pkg::XLEN-1:0] reg_val
    );
        case (sel)
            rv_pkg::FWD_MEM: return mem_fwd_i;
            rv_pkg::FWD_WB:  return wb_fwd_i;
            default:         return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a     = fwd_mux(fwd_a_i, ex.rs1_val);
        op_b_reg = fwd_mux(fwd_b_i, ex.rs2_val);
    end

    assign op_b = ex.use_imm ? ex.imm : op_b_reg;

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = op_a + op_b;
        endcase
    end

    // Branch compare uses the register operand, never the immediate
    assign taken      = ex.is_jal || (ex.is_branch && ((op_a == op_b_reg) ^ ex.branch_ne));
    assign redirect_o = id_ex_i.valid && taken;
    assign target_o   = ex.pc + ex.imm;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o.valid <= 1'b0;
        end else begin
            ex_mem_o.valid <= id_ex_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_o.payload.alu_res    <= alu_res;
        ex_mem_o.payload.store_data <= op_b_reg;
        ex_mem_o.payload.pc4        <= ex.pc + rv_pkg::XLEN'(4);
        ex_mem_o.payload.rd         <= ex.rd;
        ex_mem_o.payload.rf_we      <= ex.rf_we;
        ex_mem_o.payload.mem_we     <= ex.mem_we;
        ex_mem_o.payload.mem_re     <= ex.mem_re;
        ex_mem_o.payload.wb_sel     <= ex.wb_sel;
    end

endmodule

`default_nettype wire

// ==== source/pipe_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_fetch (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      stall_i,
    input  logic                      flush_i,
    input  logic                      redirect_i,
    input  logic [rv_pkg::XLEN-1:0]   target_i,
    output logic [rv_pkg::XLEN-1:0]   imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   imem_data_i,
    stage_if.producer                 if_id_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;

    assign imem_addr_o = pc_q;

    // Redirect takes priority over a held pc
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + rv_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_o.valid <= 1'b0;
        end else if (flush_i) begin
            if_id_o.valid <= 1'b0;
        end else if (!stall_i) begin
            if_id_o.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if_id_o.payload.pc    <= pc_q;
            if_id_o.payload.instr <= imem_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_memory #(
    parameter int DMEM_AW = 6
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    stage_if.consumer                 ex_mem_i,
    stage_if.producer                 mem_wb_o,
    output logic [DMEM_AW-1:0]        dmem_addr_o,
    output logic                      dmem_we_o,
    output logic [rv_pkg::XLEN-1:0]   dmem_wdata_o,
    input  logic [rv_pkg::XLEN-1:0]   dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0]   mem_fwd_o,
    output logic                      rf_we_o,
    output logic [4:0]                rf_idx_o,
    output logic [rv_pkg::XLEN-1:0]   rf_data_o
);

    rv_pkg::ex_mem_t         m;
    logic                    access;
    logic [rv_pkg::XLEN-1:0] wb_val;

    assign m = ex_mem_i.payload;

    // Word address, the bus stays at zero between accesses
    assign access       = ex_mem_i.valid && (m.mem_re || m.mem_we);
    assign dmem_addr_o  = access ? m.alu_res[DMEM_AW+1:2] : '0;
    assign dmem_we_o    = ex_mem_i.valid && m.mem_we;
    assign dmem_wdata_o = m.store_data;

    always_comb begin
        case (m.wb_sel)
            rv_pkg::WB_LOAD: wb_val = dmem_rdata_i;
            rv_pkg::WB_PC4:  wb_val = m.pc4;
            default:         wb_val = m.alu_res;
        endcase
    end

    assign mem_fwd_o = wb_val;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_o.valid <= 1'b0;
        end else begin
            mem_wb_o.valid <= ex_mem_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_o.payload.wdata <= wb_val;
        mem_wb_o.payload.rd    <= m.rd;
        mem_wb_o.payload.rf_we <= m.rf_we;
    end

    // Writeback port, also the WB forward source
    assign rf_we_o   = mem_wb_o.valid && mem_wb_o.payload.rf_we;
    assign rf_idx_o  = mem_wb_o.payload.rd;
    assign rf_data_o = mem_wb_o.payload.wdata;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [4:0]                rd_idx_a_i,
    input  logic [4:0]                rd_idx_b_i,
    output logic [rv_pkg::XLEN-1:0]   rd_val_a_o,
    output logic [rv_pkg::XLEN-1:0]   rd_val_b_o,
    input  logic                      we_i,
    input  logic [4:0]                wr_idx_i,
    input  logic [rv_pkg::XLEN-1:0]   wr_data_i
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wr_idx_i != 5'd0) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Write-first read, a same-cycle write is seen by decode
    function automatic logic [rv_pkg::XLEN-1:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (we_i && idx == wr_idx_i) begin
            return wr_data_i;
        end
        return regs_q[idx];
    endfunction

    always_comb begin
        rd_val_a_o = read_port(rd_idx_a_i);
        rd_val_b_o = read_port(rd_idx_b_i);
    end

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int DMEM_AW = 6
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    output logic [rv_pkg::XLEN-1:0]   imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   imem_data_i,
    output logic [DMEM_AW-1:0]        dmem_addr_o,
    output logic                      dmem_we_o,
    output logic [rv_pkg::XLEN-1:0]   dmem_wdata_o,
    input  logic [rv_pkg::XLEN-1:0]   dmem_rdata_i
);

    stage_if #(.payload_t(rv_pkg::if_id_t))  if_id_q ();
    stage_if #(.payload_t(rv_pkg::id_ex_t))  id_ex_q ();
    stage_if #(.payload_t(rv_pkg::ex_mem_t)) ex_mem_q ();
    stage_if #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_q ();

    logic                    stall;
    logic                    flush;
    logic                    redirect;
    logic [rv_pkg::XLEN-1:0] target;
    rv_pkg::fwd_sel_e        fwd_a;
    rv_pkg::fwd_sel_e        fwd_b;
    logic [4:0]              rs1_idx;
    logic [4:0]              rs2_idx;
    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] mem_fwd;
    logic                    rf_we;
    logic [4:0]              rf_idx;
    logic [rv_pkg::XLEN-1:0] rf_data;
    logic                    mem_rf_we;

    // A bubble in the memory stage never forwards
    assign mem_rf_we = ex_mem_q.valid && ex_mem_q.payload.rf_we;

    pipe_fetch i_fetch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall),
        .flush_i     (flush),
        .redirect_i  (redirect),
        .target_i    (target),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .if_id_o     (if_id_q)
    );

    pipe_decode i_decode (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .stall_i   (stall),
        .flush_i   (flush),
        .if_id_i   (if_id_q),
        .id_ex_o   (id_ex_q),
        .rs1_idx_o (rs1_idx),
        .rs2_idx_o (rs2_idx),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd_idx_a_i (rs1_idx),
        .rd_idx_b_i (rs2_idx),
        .rd_val_a_o (rs1_val),
        .rd_val_b_o (rs2_val),
        .we_i       (rf_we),
        .wr_idx_i   (rf_idx),
        .wr_data_i  (rf_data)
    );

    pipe_execute i_execute (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex_q),
        .ex_mem_o   (ex_mem_q),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .mem_fwd_i  (mem_fwd),
        .wb_fwd_i   (rf_data),
        .redirect_o (redirect),
        .target_o   (target)
    );

    pipe_memory #(
        .DMEM_AW (DMEM_AW)
    ) i_memory (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_mem_i     (ex_mem_q),
        .mem_wb_o     (mem_wb_q),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .mem_fwd_o    (mem_fwd),
        .rf_we_o      (rf_we),
        .rf_idx_o     (rf_idx),
        .rf_data_o    (rf_data)
    );

    hazard_unit i_hazard (
        .id_rs1_i    (rs1_idx),
        .id_rs2_i    (rs2_idx),
        .ex_rs1_i    (id_ex_q.payload.rs1),
        .ex_rs2_i    (id_ex_q.payload.rs2),
        .ex_rd_i     (id_ex_q.payload.rd),
        .ex_valid_i  (id_ex_q.valid),
        .ex_mem_re_i (id_ex_q.payload.mem_re),
        .mem_rd_i    (ex_mem_q.payload.rd),
        .mem_rf_we_i (mem_rf_we),
        .wb_rd_i     (rf_idx),
        .wb_rf_we_i  (rf_we),
        .redirect_i  (redirect),
        .stall_o     (stall),
        .flush_o     (flush),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b)
    );

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        logic            use_imm;
        logic            rf_we;
        logic            mem_we;
        logic            mem_re;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        wb_sel_e         wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] pc4;
        logic [4:0]      rd;
        logic            rf_we;
        logic            mem_we;
        logic            mem_re;
        wb_sel_e         wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0] wdata;
        logic [4:0]      rd;
        logic            rf_we;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== source/stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pipeline register between two stages, valid low marks a bubble
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    payload_t payload;

    modport producer (
        output valid,
        output payload
    );

    modport consumer (
        input valid,
        input payload
    );

endinterface

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
source/rv_pkg.sv
source/stage_if.sv
source/pipe_fetch.sv
source/pipe_decode.sv
source/reg_file.sv
source/pipe_execute.sv
source/pipe_memory.sv
source/hazard_unit.sv
source/rv_core.sv
dv/tb_rv_core.sv
